//--- Makefile
# Verilator build and run of tb_rv64_exec
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rv64_exec \
		-f rv64_exec.f -Mdir obj_dir -o sim_rv64_exec
	./obj_dir/sim_rv64_exec | tee $(LOG)
	@grep -qx "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- rv64_exec.f
+incdir+source
source/rv64_exec_pkg.sv
source/int_regfile.sv
source/inst_decoder.sv
source/int_alu.sv
source/writeback_unit.sv
source/rv64_exec_top.sv
tests/exec_checker.sv
tests/tb_rv64_exec.sv

//--- source/inst_decoder.sv
// RV64I only; M, CSR, fence and system encodings decode as illegal with no write
`timescale 1ns/1ps
`include "rv64_exec_settings.svh"

module inst_decoder import rv64_exec_pkg::*; (
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_valid,
    input  logic [31:0] i_inst,
    input  xword_t      i_pc,
    input  xword_t      i_rs1_data,
    input  xword_t      i_rs2_data,
    output reg_idx_t    o_rs1_addr,
    output reg_idx_t    o_rs2_addr,
    output decoded_op_t o_dec
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic        w_f3_ok;
    logic        legal;
    xword_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    decoded_op_t dec_d;

    assign opcode  = i_inst[6:0];
    assign funct3  = i_inst[14:12];
    assign funct7  = i_inst[31:25];
    assign w_f3_ok = funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101;

    assign o_rs1_addr = i_inst[19:15];
    assign o_rs2_addr = i_inst[24:20];

    assign imm_i = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {{(`RV_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    // shared by OP, OP-32, OP-IMM and OP-IMM-32
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? op_sub : op_add;
            3'b001:  return op_sll;
            3'b010:  return op_slt;
            3'b011:  return op_sltu;
            3'b100:  return op_xor;
            3'b101:  return alt ? op_sra : op_srl;
            3'b110:  return op_or;
            default: return op_and;
        endcase
    endfunction

    always_comb begin
        dec_d          = '0;
        dec_d.valid    = i_valid;
        dec_d.pc       = i_pc;
        dec_d.funct3   = funct3;
        dec_d.rs1      = i_inst[19:15];
        dec_d.rs2      = i_inst[24:20];
        dec_d.rd       = i_inst[11:7];
        dec_d.rs1_val  = i_rs1_data;
        dec_d.rs2_val  = i_rs2_data;
        dec_d.mem_kind = mem_none;
        legal          = 1'b1;
        case (opcode)
            7'b0110011, 7'b0111011: begin  // OP, OP-32
                dec_d.op    = arith_op(funct3, funct7[5]);
                dec_d.word  = opcode[3];
                dec_d.rd_we = 1'b1;
                legal = (funct7 == 7'b0000000 && (!opcode[3] || w_f3_ok))
                     || (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            7'b0010011, 7'b0011011: begin  // OP-IMM, OP-IMM-32
                dec_d.op      = arith_op(funct3, funct3 == 3'b101 && i_inst[30]);
                dec_d.word    = opcode[3];
                dec_d.imm     = imm_i;
                dec_d.use_imm = 1'b1;
                dec_d.rd_we   = 1'b1;
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    legal = (i_inst[31:26] == 6'b000000
                             || (funct3[2] && i_inst[31:26] == 6'b010000))
                         && (!opcode[3] || !i_inst[25]);  // shamt[5] only in RV64 forms
                end else begin
                    legal = !opcode[3] || funct3 == 3'b000;
                end
            end
            7'b0000011: begin
                dec_d.op       = op_add;
                dec_d.imm      = imm_i;
                dec_d.use_imm  = 1'b1;
                dec_d.mem_kind = mem_load;
                legal          = funct3 != 3'b111;
            end
            7'b0100011: begin
                dec_d.op       = op_add;
                dec_d.imm      = imm_s;
                dec_d.use_imm  = 1'b1;
                dec_d.mem_kind = mem_store;
                legal          = !funct3[2];
            end
            7'b1100011: begin
                dec_d.op  = op_branch;
                dec_d.imm = imm_b;
                legal     = funct3[2:1] != 2'b01;
            end
            7'b1100111: begin
                dec_d.op    = op_jalr;
                dec_d.imm   = imm_i;
                dec_d.rd_we = 1'b1;
                legal       = funct3 == 3'b000;
            end
            7'b1101111: begin
                dec_d.op    = op_jal;
                dec_d.imm   = imm_j;
                dec_d.rd_we = 1'b1;
            end
            7'b0110111, 7'b0010111: begin
                dec_d.op    = opcode[5] ? op_lui : op_auipc;
                dec_d.imm   = imm_u;
                dec_d.rd_we = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            dec_d.op       = op_illegal;
            dec_d.word     = 1'b0;
            dec_d.rd_we    = 1'b0;
            dec_d.mem_kind = mem_none;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dec <= '0;
        end else begin
            o_dec <= dec_d;
        end
    end

    a_store_no_write: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_valid && opcode == 7'b0100011 |=> !o_dec.rd_we && o_dec.valid);

endmodule

//--- source/int_alu.sv
// single cycle, forwards only from its own last result; loads get an address but no data
`timescale 1ns/1ps
`include "rv64_exec_settings.svh"

module int_alu import rv64_exec_pkg::*; (
    input  logic         clk,
    input  logic         i_rst_n,
    input  decoded_op_t  i_dec,
    output exec_result_t o_res
);

    logic         fwd1, fwd2;
    logic         cond, taken;
    logic [5:0]   shamt;
    xword_t       a, b_reg, b;
    xword_t       sh_in, sum, pc_imm, pc_4;
    xword_t       alu_out, st_data;
    exec_result_t res_d;

    // distance 1 bypass that never forwards x0
    assign fwd1 = o_res.valid && o_res.rd_we && o_res.rd != '0 && o_res.rd == i_dec.rs1;
    assign fwd2 = o_res.valid && o_res.rd_we && o_res.rd != '0 && o_res.rd == i_dec.rs2;

    assign a     = fwd1 ? o_res.rd_data : i_dec.rs1_val;
    assign b_reg = fwd2 ? o_res.rd_data : i_dec.rs2_val;
    assign b     = i_dec.use_imm ? i_dec.imm : b_reg;

    assign shamt = i_dec.word ? {1'b0, b[4:0]} : b[5:0];
    assign sh_in = !i_dec.word ? a
                 : i_dec.op == op_sra ? {{(`RV_XLEN-32){a[31]}}, a[31:0]}
                 : {{(`RV_XLEN-32){1'b0}}, a[31:0]};

    assign sum    = a + i_dec.imm;  // mem address, jalr target
    assign pc_imm = i_dec.pc + i_dec.imm;
    assign pc_4   = i_dec.pc + 'd4;

    always_comb begin
        case (i_dec.op)
            op_add:   alu_out = a + b;
            op_sub:   alu_out = a - b;
            op_sll:   alu_out = a << shamt;
            op_slt:   alu_out = xword_t'($signed(a) < $signed(b));
            op_sltu:  alu_out = xword_t'(a < b);
            op_xor:   alu_out = a ^ b;
            op_srl:   alu_out = sh_in >> shamt;
            op_sra:   alu_out = $signed(sh_in) >>> shamt;
            op_or:    alu_out = a | b;
            op_and:   alu_out = a & b;
            op_lui:   alu_out = i_dec.imm;
            op_auipc: alu_out = pc_imm;
            op_jal,
            op_jalr:  alu_out = pc_4;  // link value
            default:  alu_out = '0;
        endcase
    end

    always_comb begin
        case (i_dec.funct3)
            3'b000:  cond = a == b_reg;
            3'b001:  cond = a != b_reg;
            3'b100:  cond = $signed(a) < $signed(b_reg);
            3'b101:  cond = $signed(a) >= $signed(b_reg);
            3'b110:  cond = a < b_reg;
            default: cond = a >= b_reg;
        endcase
    end

    assign taken = i_dec.op == op_branch && cond;

    // sb, sh, sw, sd
    always_comb begin
        case (i_dec.funct3[1:0])
            2'b00:   st_data = xword_t'(b_reg[7:0]);
            2'b01:   st_data = xword_t'(b_reg[15:0]);
            2'b10:   st_data = xword_t'(b_reg[31:0]);
            default: st_data = b_reg;
        endcase
    end

    always_comb begin
        res_d          = '0;
        res_d.valid    = i_dec.valid;
        res_d.pc       = i_dec.pc;
        res_d.rd       = i_dec.rd;
        res_d.rd_we    = i_dec.rd_we;
        res_d.taken    = taken;
        res_d.mem_kind = i_dec.mem_kind;
        res_d.illegal  = i_dec.op == op_illegal;
        if (i_dec.rd_we) begin
            res_d.rd_data = i_dec.word ? {{(`RV_XLEN-32){alu_out[31]}}, alu_out[31:0]}
                                       : alu_out;
        end
        case (i_dec.op)
            op_jal:  res_d.next_pc = pc_imm;
            op_jalr: res_d.next_pc = {sum[`RV_XLEN-1:1], 1'b0};
            default: res_d.next_pc = taken ? pc_imm : pc_4;
        endcase
        if (i_dec.mem_kind != mem_none) begin
            res_d.mem_addr = sum;
        end
        if (i_dec.mem_kind == mem_store) begin
            res_d.store_data = st_data;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_res <= '0;
        end else begin
            o_res <= res_d;
        end
    end

    // a taken result must look like a branch record from the decoder
    a_taken_only_branch: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_res.valid && o_res.taken |-> !o_res.rd_we && o_res.mem_kind == mem_none
                                       && !o_res.illegal);

endmodule

//--- source/int_regfile.sv
// async reads with write-through, x0 reads zero, whole array cleared by reset
`timescale 1ns/1ps
`include "rv64_exec_settings.svh"

module int_regfile import rv64_exec_pkg::*; (
    input  logic     clk,
    input  logic     i_rst_n,
    input  reg_idx_t i_rs1_addr,
    input  reg_idx_t i_rs2_addr,
    input  logic     i_we,
    input  reg_idx_t i_wr_addr,
    input  xword_t   i_wr_data,
    output xword_t   o_rs1_data,
    output xword_t   o_rs2_data
);

    xword_t regs [1:`RV_NREGS-1];  // no storage behind x0

    function automatic xword_t read_port(input reg_idx_t addr);
        if (addr == '0) begin
            return '0;
        end else if (i_we && i_wr_addr == addr) begin
            return i_wr_data;  // write-through, distance 2 bypass
        end
        return regs[addr];
    endfunction

    always_comb begin
        o_rs1_data = read_port(i_rs1_addr);
        o_rs2_data = read_port(i_rs2_addr);
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_wr_addr != '0) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // writeback is expected to filter x0 before it gets here
    a_no_x0_write: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_we |-> i_wr_addr != '0);

endmodule

//--- source/rv64_exec_pkg.sv
// stage records are flat packed structs, no M extension or CSR operations encoded
`include "rv64_exec_settings.svh"

package rv64_exec_pkg;

    typedef logic [`RV_XLEN-1:0] xword_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_sll,
        op_slt,
        op_sltu,
        op_xor,
        op_srl,
        op_sra,
        op_or,
        op_and,
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_branch,
        op_illegal
    } alu_op_e;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_kind_e;

    typedef struct packed {
        logic      valid;
        xword_t    pc;
        alu_op_e   op;
        logic      word;     // W form, 32-bit operate and sign extend
        logic [2:0] funct3;  // branch condition / access size
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        logic      rd_we;
        mem_kind_e mem_kind;
        xword_t    imm;
        logic      use_imm;
        xword_t    rs1_val;
        xword_t    rs2_val;
    } decoded_op_t;

    typedef struct packed {
        logic      valid;
        xword_t    pc;
        reg_idx_t  rd;
        logic      rd_we;
        xword_t    rd_data;
        xword_t    next_pc;
        logic      taken;
        mem_kind_e mem_kind;
        xword_t    mem_addr;
        xword_t    store_data;
        logic      illegal;
    } exec_result_t;

    // same layout, rd_we already cleared for x0 and illegal
    typedef exec_result_t retire_t;

endpackage

//--- source/rv64_exec_settings.svh
// widths only; the decoder field slicing assumes 32 registers with 5-bit indices
`ifndef RV64_EXEC_SETTINGS_SVH
`define RV64_EXEC_SETTINGS_SVH

// integer data width
`define RV_XLEN 64

// architectural integer registers, x0 included
`define RV_NREGS 32

`endif

//--- source/rv64_exec_top.sv
// fixed three stage latency, no back-pressure, pc supplied by the caller
`timescale 1ns/1ps

module rv64_exec_top import rv64_exec_pkg::*; (
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_valid,
    input  logic [31:0] i_inst,
    input  xword_t      i_pc,
    output retire_t     o_retire
);

    reg_idx_t     rs1_addr, rs2_addr;
    xword_t       rs1_data, rs2_data;
    decoded_op_t  dec;
    exec_result_t res;
    logic         we;
    reg_idx_t     wr_addr;
    xword_t       wr_data;

    inst_decoder u_dec (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_inst     (i_inst),
        .i_pc       (i_pc),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_rs1_addr (rs1_addr),
        .o_rs2_addr (rs2_addr),
        .o_dec      (dec)
    );

    int_regfile u_rf (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_we       (we),
        .i_wr_addr  (wr_addr),
        .i_wr_data  (wr_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    int_alu u_alu (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_dec   (dec),
        .o_res   (res)
    );

    writeback_unit u_wb (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_res     (res),
        .o_we      (we),
        .o_wr_addr (wr_addr),
        .o_wr_data (wr_data),
        .o_retire  (o_retire)
    );

endmodule

//--- source/writeback_unit.sv
// no stall input, so every valid result retires on the next edge
`timescale 1ns/1ps

module writeback_unit import rv64_exec_pkg::*; (
    input  logic         clk,
    input  logic         i_rst_n,
    input  exec_result_t i_res,
    output logic         o_we,
    output reg_idx_t     o_wr_addr,
    output xword_t       o_wr_data,
    output retire_t      o_retire
);

    // regfile write lands on the same edge as the retire record
    assign o_we      = i_res.valid && i_res.rd_we && i_res.rd != '0;
    assign o_wr_addr = i_res.rd;
    assign o_wr_data = i_res.rd_data;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_retire <= '0;
        end else begin
            o_retire       <= i_res;
            o_retire.rd_we <= i_res.rd_we && i_res.rd != '0 && !i_res.illegal;
        end
    end

    a_illegal_no_write: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_res.valid && i_res.illegal |-> !o_we);

endmodule

//--- tests/exec_checker.sv
// model runs each instruction at issue in program order; rd and rd_data compared only on a write
`timescale 1ns/1ps
`include "rv64_exec_settings.svh"

module exec_checker import rv64_exec_pkg::*; (
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_valid,
    input  logic [31:0] i_inst,
    input  xword_t      i_pc,
    input  retire_t     i_retire,
    output int          o_mismatches,
    output int          o_unexpected,
    output int          o_pending
);

    xword_t  ref_regs [`RV_NREGS];
    retire_t exp_q [$];
    int      issue_q [$];
    retire_t exp;
    int      issued_at;
    int      cycle = 0;
    int      mismatches = 0;
    int      unexpected = 0;
    int      pending = 0;

    assign o_mismatches = mismatches;
    assign o_unexpected = unexpected;
    assign o_pending    = pending;

    function automatic xword_t alu_ref(input logic [2:0] f3, input logic alt, input logic w,
                                       input xword_t x, input xword_t y);
        xword_t      v;
        logic [31:0] x32;
        int          sh;
        sh  = w ? int'(y[4:0]) : int'(y[5:0]);
        x32 = x[31:0];
        case (f3)
            3'd0: v = alt ? x - y : x + y;
            3'd1: v = x << sh;
            3'd2: v = xword_t'($signed(x) < $signed(y));
            3'd3: v = xword_t'(x < y);
            3'd4: v = x ^ y;
            3'd5: begin
                if (w && alt) begin
                    v = 64'($signed(x32) >>> sh);
                end else if (w) begin
                    v = 64'(x32 >> sh);
                end else if (alt) begin
                    v = $signed(x) >>> sh;
                end else begin
                    v = x >> sh;
                end
            end
            3'd6: v = x | y;
            default: v = x & y;
        endcase
        return w ? 64'($signed(v[31:0])) : v;  // W forms sign extend bit 31
    endfunction

    // expected retire record, updates the model register file
    function automatic retire_t model_exec(input logic [31:0] inst, input xword_t pc);
        retire_t    e;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       w, ok, wr;
        xword_t     a, b, r, imm_i, imm_s, imm_u;
        f3    = inst[14:12];
        f7    = inst[31:25];
        w     = inst[3];
        a     = ref_regs[inst[19:15]];
        b     = ref_regs[inst[24:20]];
        imm_i = 64'($signed(inst[31:20]));
        imm_s = 64'($signed({inst[31:25], inst[11:7]}));
        imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
        ok    = 1'b1;
        wr    = 1'b0;
        r     = '0;
        e         = '0;
        e.valid   = 1'b1;
        e.pc      = pc;
        e.rd      = inst[11:7];
        e.next_pc = pc + 64'd4;
        case (inst[6:0])
            7'h33, 7'h3b: begin
                ok = (f7 == 7'h00 && (!w || f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5))
                  || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                r  = alu_ref(f3, f7[5], w, a, b);
                wr = 1'b1;
            end
            7'h13, 7'h1b: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    ok = (inst[31:26] == 6'h00 || (f3 == 3'd5 && inst[31:26] == 6'h10))
                      && !(w && inst[25]);
                end else begin
                    ok = !w || f3 == 3'd0;
                end
                r  = alu_ref(f3, f3 == 3'd5 && inst[30], w, a, imm_i);
                wr = 1'b1;
            end
            7'h03: begin
                ok         = f3 != 3'd7;
                e.mem_kind = mem_load;  // address only, no data memory
                e.mem_addr = a + imm_i;
            end
            7'h23: begin
                ok           = !f3[2];
                e.mem_kind   = mem_store;
                e.mem_addr   = a + imm_s;
                e.store_data = b & (f3[1:0] == 2'd3 ? '1 : (64'd1 << (8 << f3[1:0])) - 64'd1);
            end
            7'h63: begin
                ok = f3[2:1] != 2'b01;
                case (f3)
                    3'd0:    e.taken = a == b;
                    3'd1:    e.taken = a != b;
                    3'd4:    e.taken = $signed(a) < $signed(b);
                    3'd5:    e.taken = $signed(a) >= $signed(b);
                    3'd6:    e.taken = a < b;
                    default: e.taken = a >= b;
                endcase
                if (e.taken) begin
                    e.next_pc = pc + 64'($signed({inst[31], inst[7], inst[30:25],
                                                  inst[11:8], 1'b0}));
                end
            end
            7'h67: begin
                ok        = f3 == 3'd0;
                r         = pc + 64'd4;
                wr        = 1'b1;
                e.next_pc = (a + imm_i) & ~64'd1;
            end
            7'h6f: begin
                r         = pc + 64'd4;
                wr        = 1'b1;
                e.next_pc = pc + 64'($signed({inst[31], inst[19:12], inst[20],
                                              inst[30:21], 1'b0}));
            end
            7'h37: begin
                r  = imm_u;
                wr = 1'b1;
            end
            7'h17: begin
                r  = pc + imm_u;
                wr = 1'b1;
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            e.illegal    = 1'b1;
            e.mem_kind   = mem_none;
            e.mem_addr   = '0;
            e.store_data = '0;
            e.taken      = 1'b0;
            e.next_pc    = pc + 64'd4;
            wr           = 1'b0;
        end
        e.rd_we   = wr && inst[11:7] != 5'd0;
        e.rd_data = r;
        if (e.rd_we) begin
            ref_regs[inst[11:7]] = r;
        end
        return e;
    endfunction

    function automatic void check_field(input string name, input xword_t got, input xword_t want,
                                        input xword_t pc);
        if (got !== want) begin
            mismatches++;
            $display("error %0t ns: pc %h %s is %h, expected %h", $time, pc, name, got, want);
        end
    endfunction

    always @(posedge clk) begin
        cycle++;
        if (!i_rst_n) begin
            if (i_retire.valid) begin
                unexpected++;
                $display("o_retire.valid is high during reset at %0t ns", $time);
            end
            foreach (ref_regs[i]) begin
                ref_regs[i] = '0;
            end
            exp_q.delete();
            issue_q.delete();
        end else begin
            if (i_retire.valid && exp_q.size() == 0) begin
                unexpected++;
                $display("retire at %0t ns with no instruction outstanding", $time);
            end else if (i_retire.valid) begin
                exp       = exp_q.pop_front();
                issued_at = issue_q.pop_front();
                check_field("latency", xword_t'(cycle - issued_at), 64'd3, exp.pc);
                check_field("pc", i_retire.pc, exp.pc, exp.pc);
                check_field("rd_we", xword_t'(i_retire.rd_we), xword_t'(exp.rd_we), exp.pc);
                if (exp.rd_we) begin
                    check_field("rd", xword_t'(i_retire.rd), xword_t'(exp.rd), exp.pc);
                    check_field("rd_data", i_retire.rd_data, exp.rd_data, exp.pc);
                end
                check_field("next_pc", i_retire.next_pc, exp.next_pc, exp.pc);
                check_field("taken", xword_t'(i_retire.taken), xword_t'(exp.taken), exp.pc);
                check_field("mem_kind", xword_t'(i_retire.mem_kind), xword_t'(exp.mem_kind),
                            exp.pc);
                check_field("mem_addr", i_retire.mem_addr, exp.mem_addr, exp.pc);
                check_field("store_data", i_retire.store_data, exp.store_data, exp.pc);
                check_field("illegal", xword_t'(i_retire.illegal), xword_t'(exp.illegal), exp.pc);
            end
            if (i_valid) begin
                exp_q.push_back(model_exec(i_inst, i_pc));
                issue_q.push_back(cycle);
            end
        end
        pending = exp_q.size();
    end

endmodule

//--- tests/tb_rv64_exec.sv
// random stream uses only x0..x7 so close dependencies are frequent; seed fixed at 31
`timescale 1ns/1ps
`include "rv64_exec_settings.svh"

module tb_rv64_exec import rv64_exec_pkg::*; ();

    localparam int RST_CYCLES  = 3;
    localparam int NUM_CYCLES  = 800;
    localparam int WATCHDOG_NS = (RST_CYCLES + 8 + NUM_CYCLES + 20) * 8;

    logic        clk     = 1'b0;
    logic        i_rst_n = 1'b0;
    logic        i_valid = 1'b0;
    logic [31:0] i_inst  = '0;
    xword_t      i_pc    = '0;
    retire_t     o_retire;
    int          mismatches, unexpected, pending;
    int          drain;

    always #4 clk = ~clk;

    rv64_exec_top DUT (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_valid),
        .i_inst   (i_inst),
        .i_pc     (i_pc),
        .o_retire (o_retire)
    );

    exec_checker u_check (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_valid),
        .i_inst       (i_inst),
        .i_pc         (i_pc),
        .i_retire     (o_retire),
        .o_mismatches (mismatches),
        .o_unexpected (unexpected),
        .o_pending    (pending)
    );

    // one input slot, 1 ns after the edge
    task automatic drive(input logic v, input logic [31:0] w);
        @(posedge clk);
        #1;
        i_valid = v;
        i_inst  = w;
        i_pc    = {$urandom(), $urandom() & 32'hffff_fffc};
    endtask

    function automatic logic [31:0] random_inst();
        logic [31:0] w;
        int unsigned pick;
        w        = $urandom();
        w[11:7]  = 5'($urandom_range(0, 7));
        w[19:15] = 5'($urandom_range(0, 7));
        w[24:20] = 5'($urandom_range(0, 7));
        pick     = $urandom_range(0, 7);
        case ($urandom_range(0, 11))
            0, 1, 2: begin
                w[6:0]   = $urandom_range(0, 2) == 0 ? 7'h3b : 7'h33;
                w[31:25] = pick == 0 ? 7'h01 : pick > 4 ? 7'h20 : 7'h00;  // 0x01 is M ext
            end
            3, 4, 5: begin
                w[6:0] = $urandom_range(0, 2) == 0 ? 7'h1b : 7'h13;
                if (w[3]) begin
                    w[14:12] = pick < 3 ? 3'd0 : pick < 5 ? 3'd1 : 3'd5;
                end
                if (w[13:12] == 2'b01) begin
                    w[31:26] = (w[14] && pick[0]) ? 6'h10 : 6'h00;
                    w[25]    = w[25] && (!w[3] || pick == 7);  // rare bad W shamt
                end
            end
            6:  w[6:0] = pick[0] ? 7'h37 : 7'h17;
            7:  w[6:0] = 7'h03;
            8: begin
                w[6:0] = 7'h23;
                w[14]  = pick == 0;
            end
            9:  w[6:0] = 7'h63;
            10: begin
                w[6:0]   = pick[0] ? 7'h6f : 7'h67;
                w[14:12] = pick == 2 ? 3'd1 : 3'd0;
            end
            default: w[6:0] = pick < 3 ? 7'h0f : pick < 6 ? 7'h73 : 7'h5b;  // fence, system
        endcase
        return w;
    endfunction

    initial begin
        void'($urandom(31));
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        i_rst_n = 1'b1;
        drive(1'b1, 32'h123450b7);  // lui   x1, 0x12345
        drive(1'b1, 32'h67808093);  // addi  x1, x1, 0x678
        drive(1'b1, 32'h00108133);  // add   x2, x1, x1
        drive(1'b1, 32'h402081b3);  // sub   x3, x1, x2
        drive(1'b1, 32'hfff0821b);  // addiw x4, x1, -1
        drive(1'b1, 32'h00313423);  // sd    x3, 8(x2)
        drive(1'b1, 32'h00508013);  // addi  x0, x1, 5
        drive(1'b1, 32'h022082b3);  // mul   x5, x1, x2
        for (int n = 0; n < NUM_CYCLES; n++) begin
            drive($urandom_range(0, 4) != 0, random_inst());
        end
        drive(1'b0, 32'h0);
        drain = 0;
        while (pending != 0 && drain < 10) begin
            @(posedge clk);
            #1;
            drain++;
        end
        repeat (2) @(posedge clk);
        #1;
        $display("mismatches %0d, unexpected retires %0d, left in queue %0d",
                 mismatches, unexpected, pending);
        if (mismatches + unexpected + pending == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the instruction stream drained");
        $display("=== FAIL ===");
        $finish;
    end

endmodule
